/* leaf_node.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_node
    import leaf_pkg::*;
#(
    parameter int unsigned LEAF_ID = 1
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [PACKET_BITS-1:0] din_leaf_bft2interface,
    output wire logic [PACKET_BITS-1:0] dout_leaf_interface2bft,
    input  wire logic                   resend,
    output wire logic                   overflow
);

    // Decoder side
    wire logic [NUM_PORTS-1:0]      in_wr_en;
    wire in_item_t                  in_wr_data;
    wire logic [NUM_PORTS-1:0]      in_full;

    // Kernel side
    wire in_item_t [NUM_PORTS-1:0]  dout_leaf_interface2user;
    wire logic [NUM_PORTS-1:0]      vld_interface2user;
    wire logic [NUM_PORTS-1:0]      ack_user2interface;
    wire out_item_t [NUM_PORTS-1:0] din_leaf_user2interface;
    wire logic [NUM_PORTS-1:0]      vld_user2interface;
    wire logic [NUM_PORTS-1:0]      ack_interface2user;

    // Encoder side
    wire logic [NUM_PORTS-1:0]      out_vld;
    wire out_item_t [NUM_PORTS-1:0] out_data;
    wire logic [NUM_PORTS-1:0]      out_ack;

    packet_decoder #(
        .LEAF_ID(LEAF_ID)
    ) i_packet_decoder (
        .clk                    (clk),
        .reset                  (reset),
        .din_leaf_bft2interface (din_leaf_bft2interface),
        .wr_en                  (in_wr_en),
        .wr_data                (in_wr_data),
        .full                   (in_full),
        .overflow               (overflow)
    );

    for (genvar k = 0; k < NUM_PORTS; k++) begin : g_port
        port_buffer #(
            .item_t(in_item_t)
        ) i_in_buffer (
            .clk     (clk),
            .reset   (reset),
            .wr_en   (in_wr_en[k]),
            .wr_data (in_wr_data),                          // Shared, wr_en picks the lane
            .full    (in_full[k]),
            .vld     (vld_interface2user[k]),
            .data    (dout_leaf_interface2user[k]),
            .ack     (ack_user2interface[k])
        );

        port_buffer #(
            .item_t(out_item_t)
        ) i_out_buffer (
            .clk     (clk),
            .reset   (reset),
            .wr_en   (vld_user2interface[k]),
            .wr_data (din_leaf_user2interface[k]),
            .full    (ack_interface2user[k]),
            .vld     (out_vld[k]),
            .data    (out_data[k]),
            .ack     (out_ack[k])
        );
    end

    user_kernel i_user_kernel (
        .clk                      (clk),
        .reset                    (reset),
        .dout_leaf_interface2user (dout_leaf_interface2user),
        .vld_interface2user       (vld_interface2user),
        .ack_user2interface       (ack_user2interface),
        .din_leaf_user2interface  (din_leaf_user2interface),
        .vld_user2interface       (vld_user2interface),
        .ack_interface2user       (ack_interface2user)
    );

    packet_encoder i_packet_encoder (
        .clk                     (clk),
        .reset                   (reset),
        .resend                  (resend),
        .vld                     (out_vld),
        .data                    (out_data),
        .ack                     (out_ack),
        .dout_leaf_interface2bft (dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

/* leaf_node_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module leaf_node_assertions
    import leaf_pkg::*;
(
    input wire logic                   clk,
    input wire logic                   reset,
    input wire logic                   resend,
    input wire logic [PACKET_BITS-1:0] din,
    input wire logic [PACKET_BITS-1:0] dout,
    input wire logic                   overflow
);

    property p_quiet_during_resend;
        @(posedge clk) disable iff (reset)
            resend |-> (dout == '0);
    endproperty

    // First cycle out of reset
    property p_quiet_after_reset;
        @(posedge clk) $fell(reset) |-> (dout == '0);
    endproperty

    // Each overflow cycle needs its own dropped packet
    property p_overflow_has_packet;
        @(posedge clk) disable iff (reset)
            (overflow && $past(overflow)) |-> $past(din[VALID_POS]);
    endproperty

    a_quiet_during_resend: assert property (p_quiet_during_resend)
        else $error("Network output not zero while resend is high");

    a_quiet_after_reset: assert property (p_quiet_after_reset)
        else $error("Network output not zero right after reset");

    a_overflow_has_packet: assert property (p_overflow_has_packet)
        else $error("Overflow held for two cycles without a new packet");

endmodule

bind leaf_node leaf_node_assertions i_leaf_node_assertions (
    .clk      (clk),
    .reset    (reset),
    .resend   (resend),
    .din      (din_leaf_bft2interface),
    .dout     (dout_leaf_interface2bft),
    .overflow (overflow)
);

`default_nettype wire

/* leaf_pkg.sv */
`default_nettype none

package leaf_pkg;

    // Network packet layout
    localparam int PACKET_BITS   = 49;
    localparam int PAYLOAD_BITS  = 32;
    localparam int NUM_LEAF_BITS = 5;
    localparam int NUM_PORT_BITS = 4;
    localparam int NUM_ADDR_BITS = 7;

    localparam int NUM_PORTS     = 5;                       // Same count in and out
    localparam int PORT_IDX_BITS = $clog2(NUM_PORTS);

    // Field positions, top bit down
    localparam int VALID_POS = PACKET_BITS - 1;
    localparam int LEAF_LSB  = VALID_POS - NUM_LEAF_BITS;
    localparam int PORT_LSB  = LEAF_LSB - NUM_PORT_BITS;
    localparam int ADDR_LSB  = PORT_LSB - NUM_ADDR_BITS;    // Payload sits below

    // Port buffers
    localparam int BUF_DEPTH    = 4;
    localparam int BUF_PTR_BITS = $clog2(BUF_DEPTH);
    localparam int BUF_CNT_BITS = $clog2(BUF_DEPTH + 1);

    // Destination of each output port, lane 4 on the left
    localparam logic [NUM_PORTS-1:0][NUM_LEAF_BITS-1:0] ROUTE_LEAF = {
        5'd6, 5'd4, 5'd2, 5'd1, 5'd0
    };
    localparam logic [NUM_PORTS-1:0][NUM_PORT_BITS-1:0] ROUTE_PORT = {
        4'd5, 4'd4, 4'd3, 4'd2, 4'd1
    };

    // Word handed to the kernel
    typedef logic [PAYLOAD_BITS-1:0] in_item_t;

    // Kernel result, sequence number goes into the address field
    typedef struct packed {
        logic [NUM_ADDR_BITS-1:0] seq;
        logic [PAYLOAD_BITS-1:0]  sum;
    } out_item_t;

endpackage

`default_nettype wire

/* leaf_stimulus.txt */
# P valid leaf port addr payload_hex | R start_packet_index length_cycles
# E out_port seq sum_hex | O expected_overflow_pulses
P 1 3 1 0 00000010
P 1 3 2 0 00000020
P 1 3 3 5 00000030
P 1 3 4 0 00000040
P 1 3 5 0 00000050
P 1 2 1 0 00001111
P 1 3 0 0 00002222
P 1 3 6 0 00003333
P 0 3 1 0 00004444
P 1 3 1 0 FFFFFFF8
P 1 3 3 0 00000001
R 11 30
P 1 3 4 0 00000002
P 1 3 5 0 00000003
P 1 3 1 0 00000100
R 14 70
P 1 3 2 0 00000001
P 1 3 2 0 00000002
P 1 3 2 0 00000003
P 1 3 2 0 00000004
P 1 3 2 0 00000005
P 1 3 2 0 00000006
P 1 3 2 0 00000007
P 1 3 2 0 00000008
P 1 3 2 0 00000009
P 1 3 2 0 0000000A
P 1 3 3 0 10000000
P 1 3 1 0 00000002
P 1 3 5 0 7FFFFFFF
P 1 3 4 0 00000004
E 1 1 00000010
E 2 1 00000020
E 3 1 00000030
E 4 1 00000040
E 5 1 00000050
E 1 2 00000008
E 3 2 00000031
E 4 2 00000042
E 5 2 00000053
E 1 3 00000108
E 2 2 00000021
E 2 3 00000023
E 2 4 00000026
E 2 5 0000002A
E 2 6 0000002F
E 2 7 00000035
E 2 8 0000003C
E 2 9 00000044
E 3 3 10000031
E 1 4 0000010A
E 5 3 80000052
E 4 3 00000046
O 2

/* packet_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_decoder
    import leaf_pkg::*;
#(
    parameter int unsigned LEAF_ID = 0
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic [PACKET_BITS-1:0] din_leaf_bft2interface,
    output logic [NUM_PORTS-1:0]        wr_en,
    output in_item_t                    wr_data,
    input  wire logic [NUM_PORTS-1:0]   full,
    output logic                        overflow
);

    logic                     pkt_valid;
    logic [NUM_LEAF_BITS-1:0] pkt_leaf;
    logic [NUM_PORT_BITS-1:0] pkt_port;
    logic                     hit;
    logic [PORT_IDX_BITS-1:0] lane;

    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= din_leaf_bft2interface[VALID_POS];
        end
    end

    // Fields ride along with the valid bit
    always_ff @(posedge clk) begin
        pkt_leaf <= din_leaf_bft2interface[LEAF_LSB +: NUM_LEAF_BITS];
        pkt_port <= din_leaf_bft2interface[PORT_LSB +: NUM_PORT_BITS];
        wr_data  <= din_leaf_bft2interface[PAYLOAD_BITS-1:0];
    end

    assign hit = pkt_valid
              && (pkt_leaf == NUM_LEAF_BITS'(LEAF_ID))
              && (pkt_port != '0)
              && (pkt_port <= NUM_PORT_BITS'(NUM_PORTS));  // Ports count from 1
    assign lane = PORT_IDX_BITS'(pkt_port - 1'b1);

    always_comb begin
        wr_en    = '0;
        overflow = 1'b0;
        if (hit) begin
            if (full[lane]) begin
                overflow = 1'b1;                            // Word dropped
            end else begin
                wr_en[lane] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* packet_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_encoder
    import leaf_pkg::*;
(
    input  wire logic                     clk,
    input  wire logic                     reset,
    input  wire logic                     resend,
    input  wire logic [NUM_PORTS-1:0]     vld,
    input  wire out_item_t [NUM_PORTS-1:0] data,
    output logic [NUM_PORTS-1:0]          ack,
    output logic [PACKET_BITS-1:0]        dout_leaf_interface2bft
);

    logic [PORT_IDX_BITS-1:0] last_q;                       // Lane served last
    logic [PORT_IDX_BITS-1:0] sel;
    logic                     found;
    logic [PACKET_BITS-1:0]   next_pkt;
    logic [PACKET_BITS-1:0]   pkt_q;

    // Round robin, search starts one lane past the last winner
    always_comb begin
        int idx;
        found = 1'b0;
        sel   = last_q;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            idx = int'(last_q) + i;
            if (idx >= NUM_PORTS) begin
                idx = idx - NUM_PORTS;
            end
            if (!found && vld[idx]) begin
                found = 1'b1;
                sel   = PORT_IDX_BITS'(idx);
            end
        end
    end

    always_comb begin
        ack = '0;
        if (found && !resend) begin
            ack[sel] = 1'b1;
        end
    end

    always_comb begin
        next_pkt = '0;                                      // Empty slot when idle
        if (found) begin
            next_pkt[VALID_POS]                     = 1'b1;
            next_pkt[LEAF_LSB +: NUM_LEAF_BITS]     = ROUTE_LEAF[sel];
            next_pkt[PORT_LSB +: NUM_PORT_BITS]     = ROUTE_PORT[sel];
            next_pkt[ADDR_LSB +: NUM_ADDR_BITS]     = data[sel].seq;
            next_pkt[PAYLOAD_BITS-1:0]              = data[sel].sum;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pkt_q  <= '0;
            last_q <= PORT_IDX_BITS'(NUM_PORTS - 1);        // Lane 0 goes first
        end else if (!resend) begin
            pkt_q <= next_pkt;
            if (found) begin
                last_q <= sel;
            end
        end
    end

    // Held packet reappears once resend drops
    assign dout_leaf_interface2bft = resend ? '0 : pkt_q;

endmodule

`default_nettype wire

/* port_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module port_buffer
    import leaf_pkg::*;
#(
    parameter type item_t = in_item_t
) (
    input  wire logic  clk,
    input  wire logic  reset,
    input  wire logic  wr_en,
    input  wire item_t wr_data,
    output logic       full,
    output logic       vld,
    output item_t      data,
    input  wire logic  ack
);

    item_t                   mem [BUF_DEPTH];
    logic [BUF_PTR_BITS-1:0] wr_ptr;
    logic [BUF_PTR_BITS-1:0] rd_ptr;
    logic [BUF_CNT_BITS-1:0] count;
    logic                    push;
    logic                    pop;

    function automatic logic [BUF_PTR_BITS-1:0] ptr_inc(input logic [BUF_PTR_BITS-1:0] ptr);
        return (ptr == BUF_PTR_BITS'(BUF_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full = (count == BUF_CNT_BITS'(BUF_DEPTH));
    assign vld  = (count != '0);
    assign data = mem[rd_ptr];                              // Head of queue
    assign push = wr_en && !full;                           // Write while full is lost
    assign pop  = ack && vld;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                    // Idle or both at once
            endcase
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the leaf_node testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_leaf_node -o sim_leaf_node
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator compile failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_leaf_node 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "No errors"; then
    exit 0
fi
exit 1

/* sources.f */
leaf_pkg.sv
port_buffer.sv
packet_decoder.sv
user_kernel.sv
packet_encoder.sv
leaf_node.sv
leaf_node_assertions.sv
tb_leaf_node.sv

/* tb_leaf_node.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_leaf_node
    import leaf_pkg::*;
;

    logic                   clk;
    logic                   reset;
    logic [PACKET_BITS-1:0] din;
    logic [PACKET_BITS-1:0] dout;
    logic                   resend;
    logic                   overflow;

    // Stimulus file contents
    logic [PACKET_BITS-1:0]   pkt_mem [$];
    int                       win_start [$];
    int                       win_len [$];
    int                       exp_lane [$];
    logic [NUM_ADDR_BITS-1:0] exp_seq [$];
    logic [PAYLOAD_BITS-1:0]  exp_sum [$];
    bit                       exp_used [$];
    int                       exp_ovf = 0;
    int                       line_count = 0;

    int out_count = 0;
    int ovf_count = 0;
    int cycles = 0;
    int limit_cycles = 0;

    leaf_node #(
        .LEAF_ID(3)
    ) i_leaf_node (
        .clk                     (clk),
        .reset                   (reset),
        .din_leaf_bft2interface  (din),
        .dout_leaf_interface2bft (dout),
        .resend                  (resend),
        .overflow                (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("%0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "Run stopped after an error");
    endtask

    task automatic report_mismatch(input string name, input logic [PACKET_BITS-1:0] got,
                                   input logic [PACKET_BITS-1:0] exp);
        $display("[FAIL] %0t ns: %s expected %h, got %h", $time, name, exp, got);
        $display("Errors found");
        $fatal(1, "Run stopped after a mismatch");
    endtask

    task automatic load_stimulus();
        int             fd;
        string          line;
        int             n;
        int             f_valid;
        int             f_leaf;
        int             f_port;
        int             f_addr;
        logic [31:0]    word;
        fd = $fopen("leaf_stimulus.txt", "r");
        if (fd == 0) report_error("cannot open leaf_stimulus.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") continue;
            line_count++;
            n = 0;
            case (line.getc(0))
                "P": begin
                    n = $sscanf(line, "P %d %d %d %d %h", f_valid, f_leaf, f_port, f_addr, word);
                    pkt_mem.push_back({1'(f_valid), NUM_LEAF_BITS'(f_leaf),
                                       NUM_PORT_BITS'(f_port), NUM_ADDR_BITS'(f_addr), word});
                    n = n - 3;
                end
                "R": begin
                    n = $sscanf(line, "R %d %d", f_addr, f_leaf);
                    win_start.push_back(f_addr);
                    win_len.push_back(f_leaf);
                end
                "E": begin
                    n = $sscanf(line, "E %d %d %h", f_port, f_addr, word);
                    exp_lane.push_back(f_port - 1);              // Port k+1 is lane k
                    exp_seq.push_back(NUM_ADDR_BITS'(f_addr));
                    exp_sum.push_back(word);
                    exp_used.push_back(1'b0);
                    n = n - 1;
                end
                "O": n = 1 + $sscanf(line, "O %d", exp_ovf);
                default: report_error("unknown line kind in the stimulus file");
            endcase
            if (n != 2) report_error("malformed line in the stimulus file");
        end
        $fclose(fd);
    endtask

    task automatic hold_resend(input int len);
        fork
            begin
                int left = len;
                resend = 1'b1;
                repeat (left) @(negedge clk);
                resend = 1'b0;
            end
        join_none
    endtask

    task automatic check_output();
        logic [NUM_LEAF_BITS-1:0] leaf;
        logic [NUM_PORT_BITS-1:0] port;
        int                       lane;
        int                       idx;
        if (reset) begin
            if (cycles > 0) begin
                assert (dout == '0) else report_mismatch("dout_leaf_interface2bft", dout, '0);
                assert (overflow == 1'b0)
                    else report_mismatch("overflow", PACKET_BITS'(overflow), '0);
            end
        end else begin
            if (overflow) ovf_count++;
            if (dout[VALID_POS]) begin
                leaf = dout[LEAF_LSB +: NUM_LEAF_BITS];
                port = dout[PORT_LSB +: NUM_PORT_BITS];
                lane = -1;
                idx  = -1;
                for (int k = 0; k < NUM_PORTS; k++) begin
                    if (ROUTE_LEAF[k] == leaf && ROUTE_PORT[k] == port) lane = k;
                end
                assert (lane >= 0) else report_error("output packet carries an unknown route");
                for (int i = 0; i < exp_lane.size(); i++) begin
                    if (idx < 0 && !exp_used[i] && exp_lane[i] == lane) idx = i;   // Oldest open
                end
                assert (idx >= 0)
                    else report_error("more output packets on a lane than expected");
                assert (dout[ADDR_LSB +: NUM_ADDR_BITS] == exp_seq[idx])
                    else report_mismatch("dout_leaf_interface2bft seq",
                                         PACKET_BITS'(dout[ADDR_LSB +: NUM_ADDR_BITS]),
                                         PACKET_BITS'(exp_seq[idx]));
                assert (dout[PAYLOAD_BITS-1:0] == exp_sum[idx])
                    else report_mismatch("dout_leaf_interface2bft sum",
                                         PACKET_BITS'(dout[PAYLOAD_BITS-1:0]),
                                         PACKET_BITS'(exp_sum[idx]));
                exp_used[idx] = 1'b1;
                out_count++;
            end
        end
        cycles++;
    endtask

    always @(posedge clk) check_output();

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog: run did not finish within %0d cycles", limit_cycles);
        $display("Errors found");
        $fatal(1, "Watchdog timeout");
    end

    initial begin
        int gap;
        int win_idx;
        reset   = 1'b1;
        resend  = 1'b0;
        din     = '0;
        win_idx = 0;
        void'($urandom(26));
        load_stimulus();
        limit_cycles = 20 * line_count + 200;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        for (int i = 0; i < pkt_mem.size(); i++) begin
            if (win_idx < win_start.size() && win_start[win_idx] == i) begin
                @(negedge clk);
                din = '0;
                wait (resend == 1'b0);
                repeat (20) @(negedge clk);                     // Let the pipeline drain
                hold_resend(win_len[win_idx]);
                win_idx++;
            end
            @(negedge clk);
            din = pkt_mem[i];
            gap = $urandom_range(3, 0);
            repeat (gap) begin
                @(negedge clk);
                din = '0;
            end
        end
        @(negedge clk);
        din = '0;
        wait (resend == 1'b0);
        wait (out_count == exp_lane.size());
        repeat (30) @(negedge clk);                             // Catch stray packets
        assert (ovf_count == exp_ovf) begin
            $display("No errors");
            $finish;
        end else begin
            report_mismatch("overflow pulses", PACKET_BITS'(ovf_count),
                            PACKET_BITS'(exp_ovf));
        end
    end

endmodule

`default_nettype wire

/* user_kernel.sv */
`timescale 1ns/1ps
`default_nettype none

module user_kernel
    import leaf_pkg::*;
(
    input  wire logic                        clk,
    input  wire logic                        reset,

    input  wire in_item_t [NUM_PORTS-1:0]    dout_leaf_interface2user,
    input  wire logic [NUM_PORTS-1:0]        vld_interface2user,
    output logic [NUM_PORTS-1:0]             ack_user2interface,

    output out_item_t [NUM_PORTS-1:0]        din_leaf_user2interface,
    output logic [NUM_PORTS-1:0]             vld_user2interface,
    input  wire logic [NUM_PORTS-1:0]        ack_interface2user    // Output buffer full
);

    logic [NUM_PORTS-1:0] step;

    // A lane moves when it has a word and room for the result
    assign step               = vld_interface2user & ~ack_interface2user;
    assign ack_user2interface = step;
    assign vld_user2interface = step;

    for (genvar k = 0; k < NUM_PORTS; k++) begin : g_lane
        logic [PAYLOAD_BITS-1:0]  sum_q;
        logic [NUM_ADDR_BITS-1:0] seq_q;
        logic [PAYLOAD_BITS-1:0]  sum_next;
        logic [NUM_ADDR_BITS-1:0] seq_next;

        assign sum_next = sum_q + dout_leaf_interface2user[k];  // Wraps mod 2^32
        assign seq_next = seq_q + 1'b1;                         // First result is 1

        assign din_leaf_user2interface[k] = '{seq: seq_next, sum: sum_next};

        always_ff @(posedge clk) begin
            if (reset) begin
                sum_q <= '0;
                seq_q <= '0;
            end else if (step[k]) begin
                sum_q <= sum_next;
                seq_q <= seq_next;
            end
        end
    end

endmodule

`default_nettype wire
